// ==== design/cpu_pkg.sv ====
package cpu_pkg;

    ////////////////////////////////////////
    // data types
    ////////////////////////////////////////

    typedef logic [63:0] word_t;
    typedef logic [4:0]  reg_id_t;
    typedef logic [40:0] imm41_t;
    typedef logic [50:0] imm51_t;
    typedef logic [4:0]  shamt_t;

    // r31 doubles as the program counter
    localparam reg_id_t REG_PC = 5'd31;

    // pc step per instruction
    localparam word_t WORD_BYTES = 64'd8;

    ////////////////////////////////////////
    // encodings
    ////////////////////////////////////////

    typedef enum logic [6:0] {
        OP_NOP     = 7'h00,
        OP_SET     = 7'h01,
        OP_LOAD    = 7'h02,
        OP_STORE   = 7'h03,
        OP_JUMP    = 7'h04,
        OP_TESTBIT = 7'h05,
        OP_SUB     = 7'h06,
        OP_SHIFTL  = 7'h07,
        OP_OR      = 7'h08,
        OP_AND     = 7'h09,
        OP_XOR     = 7'h0a,
        OP_HALT    = 7'h7f
    } opcode_e;

    typedef enum logic [1:0] {
        FMT_RRO = 2'd0,
        FMT_RIS = 2'd1,
        FMT_I   = 2'd2
    } format_e;

    typedef enum logic [3:0] {
        COND_ALWAYS = 4'd0,
        COND_Z      = 4'd1,
        COND_NZ     = 4'd9
    } cond_e;

    typedef enum logic [2:0] {
        HALT,
        INIT,
        FETCH,
        DECODE,
        REG_READ,
        EXECUTE,
        REG_WRITE
    } state_e;

    ////////////////////////////////////////
    // instruction field positions
    ////////////////////////////////////////

    localparam int OPC_HI      = 63;
    localparam int OPC_LO      = 57;
    localparam int FMT_HI      = 56;
    localparam int FMT_LO      = 55;
    localparam int COND_HI     = 54;
    localparam int COND_LO     = 51;
    // first register, RIS reg or RRO destination
    localparam int RA_HI       = 50;
    localparam int RA_LO       = 46;
    // RRO source
    localparam int RB_HI       = 45;
    localparam int RB_LO       = 41;
    localparam int RIS_IMM_HI  = 45;
    localparam int RIS_IMM_LO  = 5;
    localparam int SHAMT_HI    = 4;
    localparam int SHAMT_LO    = 0;
    localparam int OFF_HI      = 40;
    localparam int OFF_LO      = 0;
    localparam int IIMM_HI     = 50;
    localparam int IIMM_LO     = 0;

endpackage

// ==== design/reg_file.sv ====
`timescale 1ns/1ns

module reg_file import cpu_pkg::*; #(
    parameter word_t RESET_PC = 64'h0000_8000_0000_0000
) (
    input  logic    clk_i,
    input  logic    rst_i,
    input  logic    we_i,
    input  reg_id_t id_i,
    input  word_t   wdata_i,
    output word_t   rdata_o
);

    word_t regs [32];

    // single port, a write cycle skips the read
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < 32; i++) begin
                if (i == int'(REG_PC)) begin
                    regs[i] <= RESET_PC;
                end else begin
                    regs[i] <= '0;
                end
            end
        end else if (we_i) begin
            regs[id_i] <= wdata_i;
        end else begin
            rdata_o <= regs[id_i];
        end
    end

    // a glitchy write enable would corrupt the pc
    a_we_known : assert property (
        @(posedge clk_i) disable iff (rst_i)
        !$isunknown(we_i)
    );

endmodule

// ==== design/instr_decode.sv ====
`timescale 1ns/1ns

module instr_decode import cpu_pkg::*; (
    input  word_t   instr_i,
    input  logic    zero_i,
    output opcode_e opcode_o,
    output format_e format_o,
    output reg_id_t dst_id_o,
    output reg_id_t src_id_o,
    output imm41_t  imm_o,
    output shamt_t  shamt_o,
    output imm51_t  imm_i_o,
    output logic    needs_dst_o,
    output logic    needs_src_o,
    output logic    cond_pass_o
);

    cond_e cond;

    assign opcode_o = opcode_e'(instr_i[OPC_HI:OPC_LO]);
    assign format_o = format_e'(instr_i[FMT_HI:FMT_LO]);
    assign cond     = cond_e'(instr_i[COND_HI:COND_LO]);

    // RIS register and RRO destination share a slot
    assign dst_id_o = instr_i[RA_HI:RA_LO];
    assign src_id_o = instr_i[RB_HI:RB_LO];

    // 41 bit immediate, RRO offset or RIS value
    assign imm_o   = (format_o == FMT_RRO) ? instr_i[OFF_HI:OFF_LO]
                                           : instr_i[RIS_IMM_HI:RIS_IMM_LO];
    assign shamt_o = instr_i[SHAMT_HI:SHAMT_LO];
    assign imm_i_o = instr_i[IIMM_HI:IIMM_LO];

    // operand reads: RRO two, RIS one, I none
    assign needs_dst_o = (format_o == FMT_RRO) || (format_o == FMT_RIS);
    assign needs_src_o = (format_o == FMT_RRO);

    always_comb begin
        case (cond)
            COND_Z:  cond_pass_o = zero_i;
            COND_NZ: cond_pass_o = !zero_i;
            // always, and unknown codes
            default: cond_pass_o = 1'b1;
        endcase
    end

endmodule

// ==== design/exec_unit.sv ====
`timescale 1ns/1ns

module exec_unit import cpu_pkg::*; (
    input  logic    clk_i,
    input  logic    rst_i,
    input  logic    exec_en_i,
    input  opcode_e opcode_i,
    input  format_e format_i,
    input  word_t   dst_val_i,
    input  word_t   src_val_i,
    input  imm41_t  imm_i,
    input  shamt_t  shamt_i,
    input  imm51_t  imm_i_i,
    input  word_t   mem_rdata_i,
    output word_t   wb_data_o,
    output word_t   mem_adr_o,
    output logic    writes_reg_o,
    output logic    zero_o
);

    word_t imm_ext;
    word_t sub_res;
    logic  bit_clear;

    assign imm_ext   = word_t'(imm_i);
    assign sub_res   = dst_val_i - imm_ext;
    assign bit_clear = (dst_val_i & (word_t'(1) << imm_i)) == '0;

    // store addresses off the destination, load off the source
    assign mem_adr_o = ((opcode_i == OP_STORE) ? dst_val_i : src_val_i) + imm_ext;

    ////////////////////////////////////////
    // write-back value
    ////////////////////////////////////////

    always_comb begin
        wb_data_o    = '0;
        writes_reg_o = 1'b0;
        case (opcode_i)
            OP_SET: begin
                writes_reg_o = 1'b1;
                if (format_i == FMT_RIS) begin
                    wb_data_o = imm_ext << shamt_i;
                end else begin
                    wb_data_o = src_val_i;
                end
            end
            OP_SUB: begin
                writes_reg_o = 1'b1;
                wb_data_o    = sub_res;
            end
            OP_SHIFTL: begin
                writes_reg_o = 1'b1;
                wb_data_o    = dst_val_i << imm_i;
            end
            OP_OR: begin
                writes_reg_o = 1'b1;
                wb_data_o    = dst_val_i | src_val_i;
            end
            OP_AND: begin
                writes_reg_o = 1'b1;
                wb_data_o    = dst_val_i & src_val_i;
            end
            OP_XOR: begin
                writes_reg_o = 1'b1;
                wb_data_o    = dst_val_i ^ src_val_i;
            end
            OP_JUMP: begin
                // new pc, absolute or through a register
                writes_reg_o = 1'b1;
                if (format_i == FMT_I) begin
                    wb_data_o = word_t'(imm_i_i);
                end else begin
                    wb_data_o = dst_val_i;
                end
            end
            OP_LOAD: begin
                writes_reg_o = 1'b1;
                wb_data_o    = mem_rdata_i;
            end
            default: begin
                writes_reg_o = 1'b0;
            end
        endcase
    end

    // zero flag, only sub and testbit touch it
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            zero_o <= 1'b0;
        end else if (exec_en_i) begin
            if (opcode_i == OP_SUB) begin
                zero_o <= (sub_res == '0);
            end else if (opcode_i == OP_TESTBIT) begin
                zero_o <= bit_clear;
            end
        end
    end

endmodule

// ==== design/cpu_control.sv ====
`timescale 1ns/1ns

module cpu_control import cpu_pkg::*; (
    input  logic    clk_i,
    input  logic    rst_i,
    // bus master
    output logic    stb_o,
    output logic    we_o,
    output word_t   adr_o,
    output word_t   dat_o,
    input  word_t   dat_i,
    input  logic    ack_i,
    input  logic    err_i,
    // register file
    output logic    rf_we_o,
    output reg_id_t rf_id_o,
    output word_t   rf_wdata_o,
    input  word_t   rf_rdata_i,
    // decode
    output word_t   instr_o,
    input  opcode_e opcode_i,
    input  reg_id_t dst_id_i,
    input  reg_id_t src_id_i,
    input  logic    needs_dst_i,
    input  logic    needs_src_i,
    input  logic    cond_pass_i,
    // execute
    output word_t   dst_val_o,
    output word_t   src_val_o,
    output logic    exec_en_o,
    input  word_t   wb_data_i,
    input  word_t   mem_adr_i,
    input  logic    writes_reg_i
);

    state_e     state;
    logic [1:0] phase;

    // one cycle per instruction, on the first execute cycle
    assign exec_en_o = (state == EXECUTE) && (phase == 2'd0);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state   <= INIT;
            phase   <= 2'd0;
            stb_o   <= 1'b0;
            we_o    <= 1'b0;
            rf_we_o <= 1'b0;
            rf_id_o <= REG_PC;
        end else begin
            case (state)
                INIT: begin
                    rf_id_o <= REG_PC;
                    phase   <= 2'd0;
                    state   <= FETCH;
                end
                FETCH: begin
                    // phase 0 lets the pc read settle
                    if (phase == 2'd0) begin
                        phase <= 2'd1;
                    end else begin
                        stb_o      <= 1'b1;
                        we_o       <= 1'b0;
                        adr_o      <= rf_rdata_i;
                        rf_we_o    <= 1'b1;
                        rf_wdata_o <= rf_rdata_i + WORD_BYTES;
                        phase      <= 2'd0;
                        state      <= DECODE;
                    end
                end
                DECODE: begin
                    rf_we_o <= 1'b0;
                    if (phase == 2'd0) begin
                        if (ack_i) begin
                            stb_o   <= 1'b0;
                            instr_o <= dat_i;
                            phase   <= 2'd1;
                        end else if (err_i) begin
                            stb_o <= 1'b0;
                            state <= HALT;
                        end
                    end else begin
                        // condition test on the latched word
                        phase <= 2'd0;
                        if (!cond_pass_i) begin
                            state <= REG_WRITE;
                        end else if (needs_dst_i) begin
                            rf_id_o <= dst_id_i;
                            state   <= REG_READ;
                        end else begin
                            state <= EXECUTE;
                        end
                    end
                end
                REG_READ: begin
                    case (phase)
                        2'd0: begin
                            if (needs_src_i) begin
                                rf_id_o <= src_id_i;
                            end
                            phase <= 2'd1;
                        end
                        2'd1: begin
                            dst_val_o <= rf_rdata_i;
                            if (needs_src_i) begin
                                phase <= 2'd2;
                            end else begin
                                phase <= 2'd0;
                                state <= EXECUTE;
                            end
                        end
                        default: begin
                            src_val_o <= rf_rdata_i;
                            phase     <= 2'd0;
                            state     <= EXECUTE;
                        end
                    endcase
                end
                EXECUTE: begin
                    if (opcode_i == OP_LOAD || opcode_i == OP_STORE) begin
                        // one bus cycle, err ends it like ack
                        if (phase == 2'd0) begin
                            stb_o <= 1'b1;
                            we_o  <= (opcode_i == OP_STORE);
                            adr_o <= mem_adr_i;
                            dat_o <= src_val_o;
                            phase <= 2'd1;
                        end else if (ack_i || err_i) begin
                            stb_o <= 1'b0;
                            we_o  <= 1'b0;
                            phase <= 2'd0;
                            state <= REG_WRITE;
                            if (opcode_i == OP_LOAD) begin
                                rf_we_o    <= 1'b1;
                                rf_id_o    <= dst_id_i;
                                rf_wdata_o <= wb_data_i;
                            end
                        end
                    end else if (opcode_i == OP_HALT) begin
                        state <= HALT;
                    end else begin
                        if (writes_reg_i) begin
                            rf_we_o    <= 1'b1;
                            rf_id_o    <= (opcode_i == OP_JUMP) ? REG_PC : dst_id_i;
                            rf_wdata_o <= wb_data_i;
                        end
                        state <= REG_WRITE;
                    end
                end
                REG_WRITE: begin
                    // write lands here, then point back at the pc
                    rf_we_o <= 1'b0;
                    rf_id_o <= REG_PC;
                    phase   <= 2'd0;
                    state   <= FETCH;
                end
                default: begin
                    // halted until reset
                    stb_o   <= 1'b0;
                    we_o    <= 1'b0;
                    rf_we_o <= 1'b0;
                end
            endcase
        end
    end

    ////////////////////////////////////////
    // bus handshake checks
    ////////////////////////////////////////

    a_stb_held : assert property (
        @(posedge clk_i) disable iff (rst_i)
        (stb_o && !ack_i && !err_i) |=> stb_o
    );

    a_adr_stable : assert property (
        @(posedge clk_i) disable iff (rst_i)
        (stb_o && !ack_i && !err_i) |=> ($stable(adr_o) && $stable(we_o))
    );

endmodule

// ==== design/cpu_top.sv ====
`timescale 1ns/1ns

module cpu_top import cpu_pkg::*; #(
    parameter word_t RESET_PC = 64'h0000_8000_0000_0000
) (
    input  logic  clk_i,
    input  logic  rst_i,
    output logic  stb_o,
    output logic  we_o,
    output word_t adr_o,
    output word_t dat_o,
    input  word_t dat_i,
    input  logic  ack_i,
    input  logic  err_i
);

    logic    rf_we;
    reg_id_t rf_id;
    word_t   rf_wdata;
    word_t   rf_rdata;

    word_t   instr;
    opcode_e opcode;
    format_e format;
    reg_id_t dst_id;
    reg_id_t src_id;
    imm41_t  imm;
    shamt_t  shamt;
    imm51_t  imm_i;
    logic    needs_dst;
    logic    needs_src;
    logic    cond_pass;

    word_t   dst_val;
    word_t   src_val;
    logic    exec_en;
    word_t   wb_data;
    word_t   mem_adr;
    logic    writes_reg;
    logic    zero;

    reg_file #(
        .RESET_PC(RESET_PC)
    ) u_reg_file (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .we_i    (rf_we),
        .id_i    (rf_id),
        .wdata_i (rf_wdata),
        .rdata_o (rf_rdata)
    );

    instr_decode u_decode (
        .instr_i     (instr),
        .zero_i      (zero),
        .opcode_o    (opcode),
        .format_o    (format),
        .dst_id_o    (dst_id),
        .src_id_o    (src_id),
        .imm_o       (imm),
        .shamt_o     (shamt),
        .imm_i_o     (imm_i),
        .needs_dst_o (needs_dst),
        .needs_src_o (needs_src),
        .cond_pass_o (cond_pass)
    );

    exec_unit u_exec (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .exec_en_i    (exec_en),
        .opcode_i     (opcode),
        .format_i     (format),
        .dst_val_i    (dst_val),
        .src_val_i    (src_val),
        .imm_i        (imm),
        .shamt_i      (shamt),
        .imm_i_i      (imm_i),
        .mem_rdata_i  (dat_i),
        .wb_data_o    (wb_data),
        .mem_adr_o    (mem_adr),
        .writes_reg_o (writes_reg),
        .zero_o       (zero)
    );

    cpu_control u_control (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .stb_o        (stb_o),
        .we_o         (we_o),
        .adr_o        (adr_o),
        .dat_o        (dat_o),
        .dat_i        (dat_i),
        .ack_i        (ack_i),
        .err_i        (err_i),
        .rf_we_o      (rf_we),
        .rf_id_o      (rf_id),
        .rf_wdata_o   (rf_wdata),
        .rf_rdata_i   (rf_rdata),
        .instr_o      (instr),
        .opcode_i     (opcode),
        .dst_id_i     (dst_id),
        .src_id_i     (src_id),
        .needs_dst_i  (needs_dst),
        .needs_src_i  (needs_src),
        .cond_pass_i  (cond_pass),
        .dst_val_o    (dst_val),
        .src_val_o    (src_val),
        .exec_en_o    (exec_en),
        .wb_data_i    (wb_data),
        .mem_adr_i    (mem_adr),
        .writes_reg_i (writes_reg)
    );

endmodule

// ==== tb/bus_mem.sv ====
`timescale 1ns/1ns

module bus_mem import cpu_pkg::*; (
    input  logic  clk_i,
    input  logic  rst_i,
    input  logic  stb_i,
    input  logic  we_i,
    input  word_t adr_i,
    input  word_t dat_i,
    output word_t dat_o,
    output logic  ack_o,
    output logic  err_o,
    // one address that answers with err instead of ack
    input  logic  err_en_i,
    input  word_t err_adr_i
);

    // 512 words, decoded from adr bits 11:3
    word_t  mem [512];
    integer seed;
    integer rnd;
    integer delay;
    logic   armed;

    initial begin
        seed  = 17;
        rnd   = 0;
        delay = 0;
        armed = 1'b0;
        ack_o = 1'b0;
        err_o = 1'b0;
        dat_o = '0;
        for (int i = 0; i < 512; i++) begin
            mem[i] = ~(word_t'(i) * 64'h0001_0003_0007_000f);
        end
    end

    // answers change on the falling edge, 0 to 3 wait cycles per request
    always @(negedge clk_i) begin
        if (rst_i || !stb_i || ack_o || err_o) begin
            ack_o <= 1'b0;
            err_o <= 1'b0;
            armed = 1'b0;
        end else begin
            if (!armed) begin
                rnd   = $random(seed);
                delay = rnd & 3;
                armed = 1'b1;
            end
            if (delay != 0) begin
                delay = delay - 1;
            end else if (err_en_i && adr_i == err_adr_i) begin
                err_o <= 1'b1;
            end else begin
                ack_o <= 1'b1;
                if (we_i) begin
                    mem[adr_i[11:3]] = dat_i;
                end else begin
                    dat_o <= mem[adr_i[11:3]];
                end
            end
        end
    end

endmodule

// ==== tb/tb_cpu.sv ====
`timescale 1ns/1ns

module tb_cpu import cpu_pkg::*; ();

    localparam word_t RESET_PC  = 64'h0000_8000_0000_0000;
    localparam int    MAX_INSTR = 24;
    localparam int    N_TESTS   = 6;
    localparam int    CYCLE_NS  = 100;

    logic  clk_i;
    logic  rst_i;
    logic  stb_o;
    logic  we_o;
    word_t adr_o;
    word_t dat_o;
    word_t dat_i;
    logic  ack_i;
    logic  err_i;
    logic  err_en;
    word_t err_adr;
    logic  quiet;
    logic  xfer;

    // expected bus cycles in order, packed as {we, adr, dat}
    logic [128:0] exp_q [$];
    logic         exp_valid;
    logic         exp_we;
    word_t        exp_adr;
    word_t        exp_dat;

    word_t  pc;
    integer seed;
    int     errors;
    int     errors_before;
    int     tests_run;
    int     tests_failed;

    cpu_top #(
        .RESET_PC(RESET_PC)
    ) uut (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .stb_o (stb_o),
        .we_o  (we_o),
        .adr_o (adr_o),
        .dat_o (dat_o),
        .dat_i (dat_i),
        .ack_i (ack_i),
        .err_i (err_i)
    );

    bus_mem mem_model (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .stb_i     (stb_o),
        .we_i      (we_o),
        .adr_i     (adr_o),
        .dat_i     (dat_o),
        .dat_o     (dat_i),
        .ack_o     (ack_i),
        .err_o     (err_i),
        .err_en_i  (err_en),
        .err_adr_i (err_adr)
    );

    initial clk_i = 1'b0;
    always #(CYCLE_NS / 2) clk_i = ~clk_i;

    initial begin
        #(longint'(MAX_INSTR) * 40 * N_TESTS * CYCLE_NS);
        $display("timeout: the run did not end within %0d cycles", MAX_INSTR * 40 * N_TESTS);
        $display("TESTS FAILED");
        $finish;
    end

    ////////////////////////////////////////
    // instruction assembly
    ////////////////////////////////////////

    function automatic word_t ris(opcode_e op, cond_e c, reg_id_t r, imm41_t imm, shamt_t sh);
        return {op, FMT_RIS, c, r, imm, sh};
    endfunction

    function automatic word_t rro(opcode_e op, cond_e c, reg_id_t d, reg_id_t s, imm41_t off);
        return {op, FMT_RRO, c, d, s, off};
    endfunction

    function automatic word_t ifm(opcode_e op, cond_e c, imm51_t imm);
        return {op, FMT_I, c, imm};
    endfunction

    task expect_cycle(input logic we, input word_t adr, input word_t dat);
        exp_q.push_back({we, adr, dat});
    endtask

    // place one word at pc, its fetch is expected next
    task ins(input word_t w);
        mem_model.mem[pc[11:3]] = w;
        expect_cycle(1'b0, pc, '0);
        pc = pc + WORD_BYTES;
    endtask

    // store [r0 + adr] from src, checked only when the condition holds
    task store_op(input cond_e c, input reg_id_t src, input word_t adr, input word_t dat,
                  input logic taken);
        ins(rro(OP_STORE, c, 5'd0, src, imm41_t'(adr)));
        if (taken) begin
            expect_cycle(1'b1, adr, dat);
        end
    endtask

    task load_head();
        if (exp_q.size() > 0) begin
            {exp_we, exp_adr, exp_dat} = exp_q[0];
            exp_valid = 1'b1;
        end else begin
            exp_valid = 1'b0;
        end
    endtask

    task begin_run(input logic use_err, input word_t bad_adr);
        @(negedge clk_i);
        rst_i   <= 1'b1;
        err_en  <= use_err;
        err_adr <= bad_adr;
        exp_q.delete();
        pc = RESET_PC;
        errors_before = errors;
    endtask

    task end_run(input string name);
        load_head();
        repeat (3) @(negedge clk_i);
        rst_i <= 1'b0;
        while (exp_q.size() != 0) begin
            @(negedge clk_i);
        end
        // halted, the bus must stay idle
        quiet <= 1'b1;
        repeat (50) @(negedge clk_i);
        quiet <= 1'b0;
        tests_run++;
        if (errors != errors_before) begin
            tests_failed++;
        end
        $display("%-12s %s", name, (errors == errors_before) ? "ok" : "failed");
    endtask

    // retire each finished bus cycle
    always @(posedge clk_i) begin
        if (!rst_i && stb_o && (ack_i || err_i) && exp_q.size() > 0) begin
            void'(exp_q.pop_front());
            load_head();
        end
    end

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////

    assign xfer = stb_o && (ack_i || err_i);

    a_reset_idle : assert property (@(posedge clk_i) (rst_i ##1 rst_i) |-> (!stb_o && !we_o))
        else begin
            errors = errors + 1;
            $display("[ERROR] %0t ns: bus active during reset", $time);
        end

    a_first_fetch : assert property (
        @(posedge clk_i) $fell(rst_i) |-> !stb_o ##1 !stb_o ##1 !stb_o ##1 stb_o
    ) else begin
        errors = errors + 1;
        $display("[ERROR] %0t ns: first fetch strobe not 3 cycles after reset", $time);
    end

    a_bus_expected : assert property (@(posedge clk_i) disable iff (rst_i) xfer |-> exp_valid)
        else begin
            errors = errors + 1;
            $display("[ERROR] %0t ns: unexpected bus cycle at %h", $time, $sampled(adr_o));
        end

    a_bus_dir : assert property (
        @(posedge clk_i) disable iff (rst_i) (xfer && exp_valid) |-> (we_o == exp_we)
    ) else begin
        errors = errors + 1;
        $display("[ERROR] %0t ns: we %b, expected %b", $time, $sampled(we_o), $sampled(exp_we));
    end

    a_bus_adr : assert property (
        @(posedge clk_i) disable iff (rst_i) (xfer && exp_valid) |-> (adr_o == exp_adr)
    ) else begin
        errors = errors + 1;
        $display("[ERROR] %0t ns: address %h, expected %h", $time, $sampled(adr_o),
                 $sampled(exp_adr));
    end

    a_store_data : assert property (
        @(posedge clk_i) disable iff (rst_i) (xfer && exp_valid && we_o) |-> (dat_o == exp_dat)
    ) else begin
        errors = errors + 1;
        $display("[ERROR] %0t ns: store data %h, expected %h", $time, $sampled(dat_o),
                 $sampled(exp_dat));
    end

    a_halt_idle : assert property (@(posedge clk_i) quiet |-> !stb_o)
        else begin
            errors = errors + 1;
            $display("[ERROR] %0t ns: strobe raised after halt", $time);
        end

    ////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////

    initial begin
        word_t a;
        word_t b;
        word_t val;
        word_t ld_adr;
        rst_i = 1'b1;
        err_en = 1'b0;
        err_adr = '0;
        quiet = 1'b0;
        exp_valid = 1'b0;
        exp_we = 1'b0;
        exp_adr = '0;
        exp_dat = '0;
        pc = RESET_PC;
        seed = 17;
        errors = 0;
        errors_before = 0;
        tests_run = 0;
        tests_failed = 0;

        // fetch timing and pc steps
        begin_run(1'b0, '0);
        repeat (3) ins(ifm(OP_NOP, COND_ALWAYS, '0));
        ins(ifm(OP_HALT, COND_ALWAYS, '0));
        end_run("reset_fetch");

        // logic and arithmetic
        begin_run(1'b0, '0);
        a = 64'h1234 << 8;
        b = 64'hf0f0 << 4;
        ins(ris(OP_SET, COND_ALWAYS, 5'd1, 41'h1234, 5'd8));
        ins(ris(OP_SET, COND_ALWAYS, 5'd2, 41'hf0f0, 5'd4));
        ins(rro(OP_SET, COND_ALWAYS, 5'd3, 5'd1, '0));
        ins(rro(OP_OR, COND_ALWAYS, 5'd3, 5'd2, '0));
        store_op(COND_ALWAYS, 5'd3, 64'h200, a | b, 1'b1);
        ins(rro(OP_SET, COND_ALWAYS, 5'd4, 5'd1, '0));
        ins(rro(OP_AND, COND_ALWAYS, 5'd4, 5'd2, '0));
        store_op(COND_ALWAYS, 5'd4, 64'h208, a & b, 1'b1);
        ins(rro(OP_SET, COND_ALWAYS, 5'd5, 5'd1, '0));
        ins(rro(OP_XOR, COND_ALWAYS, 5'd5, 5'd2, '0));
        store_op(COND_ALWAYS, 5'd5, 64'h210, a ^ b, 1'b1);
        ins(ris(OP_SUB, COND_ALWAYS, 5'd1, 41'h34, '0));
        store_op(COND_ALWAYS, 5'd1, 64'h218, a - 64'h34, 1'b1);
        ins(ris(OP_SHIFTL, COND_ALWAYS, 5'd2, 41'd3, '0));
        store_op(COND_ALWAYS, 5'd2, 64'h220, b << 3, 1'b1);
        ins(ifm(OP_HALT, COND_ALWAYS, '0));
        end_run("alu");

        // sub to zero, then testbit on a set bit
        begin_run(1'b0, '0);
        ins(ris(OP_SET, COND_ALWAYS, 5'd1, 41'd5, '0));
        ins(ris(OP_SUB, COND_ALWAYS, 5'd1, 41'd5, '0));
        store_op(COND_Z, 5'd1, 64'h300, '0, 1'b1);
        store_op(COND_NZ, 5'd1, 64'h308, '0, 1'b0);
        ins(ris(OP_SET, COND_ALWAYS, 5'd2, 41'd1, 5'd6));
        ins(ris(OP_TESTBIT, COND_ALWAYS, 5'd2, 41'd6, '0));
        store_op(COND_Z, 5'd2, 64'h310, 64'h40, 1'b0);
        store_op(COND_NZ, 5'd2, 64'h318, 64'h40, 1'b1);
        ins(ifm(OP_HALT, COND_ALWAYS, '0));
        end_run("condition");

        // copy four data words through r2
        begin_run(1'b0, '0);
        ins(ris(OP_SET, COND_ALWAYS, 5'd1, 41'h400, '0));
        for (int k = 0; k < 4; k++) begin
            val = {$random(seed), $random(seed)};
            ld_adr = 64'h418 + word_t'(8 * k);
            mem_model.mem[ld_adr[11:3]] = val;
            ins(rro(OP_LOAD, COND_ALWAYS, 5'd2, 5'd1, imm41_t'(ld_adr - 64'h400)));
            expect_cycle(1'b0, ld_adr, '0);
            store_op(COND_ALWAYS, 5'd2, 64'h500 + word_t'(8 * k), val, 1'b1);
        end
        ins(ifm(OP_HALT, COND_ALWAYS, '0));
        end_run("load_store");

        // absolute jump, then through r1
        begin_run(1'b0, '0);
        a = RESET_PC + 64'h80;
        b = RESET_PC + 64'h100;
        ins(ifm(OP_JUMP, COND_ALWAYS, imm51_t'(a)));
        pc = a;
        ins(ris(OP_SET, COND_ALWAYS, 5'd1, 41'h80_0000_0001, 5'd8));
        ins(ris(OP_JUMP, COND_ALWAYS, 5'd1, '0, '0));
        pc = b;
        ins(ifm(OP_HALT, COND_ALWAYS, '0));
        end_run("jump");

        // third fetch answers with err
        begin_run(1'b1, RESET_PC + 64'h10);
        ins(ifm(OP_NOP, COND_ALWAYS, '0));
        ins(ifm(OP_NOP, COND_ALWAYS, '0));
        ins(rro(OP_STORE, COND_ALWAYS, 5'd0, 5'd31, 41'h600));
        end_run("fetch_err");

        $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
design/cpu_pkg.sv
design/reg_file.sv
design/instr_decode.sv
design/exec_unit.sv
design/cpu_control.sv
design/cpu_top.sv
tb/bus_mem.sv
tb/tb_cpu.sv
